/* common/dcache_addr_pkg.sv */
/*
  data cache address and data types
  field widths and address split helpers
*/
`default_nettype none

package dcache_addr_pkg;
  `include "dcache_config.svh"

  localparam int BE_W   = `DC_XLEN / 8;
  localparam int IDX_W  = $clog2(`DC_SETS);
  localparam int WOFF_W = $clog2(`DC_BEATS);
  localparam int BOFF_W = $clog2(BE_W);     // byte in word
  localparam int LOFF_W = WOFF_W + BOFF_W;  // byte in line
  localparam int TAG_W  = `DC_XLEN - IDX_W - LOFF_W;

  typedef logic [`DC_XLEN-1:0]              word_t;
  typedef logic [BE_W-1:0]                  be_t;
  typedef logic [`DC_XLEN-1:0]              adr_t;
  typedef logic [IDX_W-1:0]                 idx_t;
  typedef logic [TAG_W-1:0]                 tag_t;
  typedef logic [WOFF_W-1:0]                woff_t;
  typedef logic [`DC_BEATS-1:0][`DC_XLEN-1:0] line_t;  // word 0 at the bottom
  typedef logic [`DC_WAYS-1:0]              way_t;     // one-hot

  function automatic idx_t adr_idx(adr_t a);
    return a[LOFF_W +: IDX_W];
  endfunction

  function automatic tag_t adr_tag(adr_t a);
    return a[`DC_XLEN-1 -: TAG_W];
  endfunction

  function automatic woff_t adr_woff(adr_t a);
    return a[BOFF_W +: WOFF_W];
  endfunction

  // line aligned address from tag and set
  function automatic adr_t make_adr(tag_t t, idx_t i);
    return {t, i, {LOFF_W{1'b0}}};
  endfunction
endpackage

`default_nettype wire

/* common/dcache_array_if.sv */
/*
  controller to tag/data store link
  index, write strobes, way select and lookup results
*/
`timescale 1ns/1ps
`default_nettype none

interface dcache_array_if import dcache_addr_pkg::*; ();
  idx_t  acc_idx;     // set to read, and to write at the edge
  logic  fill_we;     // whole line + tag into sel_way
  logic  store_we;    // word write on sel_way, sets dirty
  logic  clean_we;    // clear dirty of sel_way
  way_t  sel_way;
  way_t  hit;         // one-hot, against request tag
  way_t  dirty_vec;
  tag_t  victim_tag;  // tag of sel_way
  line_t sel_line;    // line of sel_way

  modport ctrl (
    output acc_idx, fill_we, store_we, clean_we, sel_way,
    input  hit, dirty_vec, victim_tag, sel_line
  );
  modport tags (
    input  acc_idx, fill_we, store_we, clean_we, sel_way,
    output hit, dirty_vec, victim_tag
  );
  modport data (
    input  acc_idx, fill_we, store_we, sel_way, hit,
    output sel_line
  );
endinterface

`default_nettype wire

/* common/dcache_config.svh */
/*
  data cache sizing
  word width, associativity, sets, line length and victim LFSR seed
*/
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// ------------------------------
// geometry
// ------------------------------
`define DC_XLEN  32    // bits per word
`define DC_WAYS  2     // associativity
`define DC_SETS  16    // sets per way
`define DC_BEATS 4     // words per line, also burst length

// ------------------------------
// replacement
// ------------------------------
`define DC_LFSR_SEED 16'hace1  // must not be zero

`endif

/* common/dcache_ctrl_pkg.sv */
/*
  data cache control encodings
  access FSM, burst FSM and line command
*/
`default_nettype none

package dcache_ctrl_pkg;

  // access side
  typedef enum logic [2:0] {
    ARMED, FILL, EVICT, FLUSH_SCAN, FLUSH_WB, RECOVER
  } miss_state_e;

  // memory side
  typedef enum logic [1:0] {IDLE, WAIT_GNT, BURST} bus_state_e;

  // miss controller to bus controller
  typedef enum logic [1:0] {NOP, READ_LINE, WRITE_LINE} bus_cmd_e;

endpackage

`default_nettype wire

/* common/dcache_line_if.sv */
/*
  miss controller to bus controller link
  one line command at a time, done closes it
*/
`timescale 1ns/1ps
`default_nettype none

interface dcache_line_if
  import dcache_addr_pkg::*;
  import dcache_ctrl_pkg::*;
();
  bus_cmd_e cmd;       // held until done
  adr_t     line_adr;  // line aligned
  line_t    wline;     // write-back data
  line_t    rline;     // fill data, complete at done
  logic     done;      // one cycle, last beat

  modport miss (
    output cmd, line_adr, wline,
    input  rline, done
  );
  modport bus (
    input  cmd, line_adr, wline,
    output rline, done
  );
endinterface

`default_nettype wire

/* dcache/dcache_bus_ctrl.sv */
/*
  burst controller that strobes until granted and then moves one line of beats
  fill assembly and evict shift buffer
*/
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_bus_ctrl
  import dcache_addr_pkg::*;
  import dcache_ctrl_pkg::*;
(
  input  wire logic   clk_i,
  input  wire logic   rst_ni,
  output logic        biu_stb_o,
  input  wire logic   biu_stb_ack_i,
  output logic        biu_we_o,
  output adr_t        biu_adr_o,
  output word_t       biu_d_o,
  input  wire word_t  biu_q_i,
  input  wire logic   biu_ack_i,
  dcache_line_if.bus  line
);

  bus_state_e state_q;
  woff_t      cnt_q;   // beat number
  logic       we_q;
  adr_t       adr_q;
  line_t      ebuf_q;  // evict shift buffer with word 0 on the bus
  line_t      fill_q;
  line_t      rline;
  logic       last;

  assign last = (cnt_q == woff_t'(`DC_BEATS-1));

  // ------------------------------
  // bus outputs
  // ------------------------------
  assign biu_stb_o = (state_q == WAIT_GNT);
  assign biu_we_o  = we_q;
  assign biu_adr_o = adr_q;
  assign biu_d_o   = ebuf_q[0];

  // last beat straight from the bus
  always_comb
  begin
    rline        = fill_q;
    rline[cnt_q] = biu_q_i;
  end

  assign line.rline = rline;
  assign line.done  = (state_q == BURST) & biu_ack_i & last;

  // ------------------------------
  // FSM
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end
    else
    begin
      case (state_q)
        IDLE     : if (line.cmd != NOP) state_q <= WAIT_GNT;
        WAIT_GNT : if (biu_stb_ack_i)
                   begin
                     state_q <= BURST;
                     cnt_q   <= '0;
                   end
        BURST    : if (biu_ack_i)
                   begin
                     cnt_q <= cnt_q + 1'b1;
                     if (last) state_q <= IDLE;
                   end
        default  : state_q <= IDLE;
      endcase
    end
  end

  // command latch and beat data
  always_ff @(posedge clk_i)
  begin
    if ((state_q == IDLE) && (line.cmd != NOP))
    begin
      we_q   <= (line.cmd == WRITE_LINE);
      adr_q  <= line.line_adr;
      ebuf_q <= line.wline;
    end
    else if ((state_q == BURST) && biu_ack_i)
    begin
      ebuf_q <= {word_t'(0), ebuf_q[`DC_BEATS-1:1]};  // next beat down
      if (!we_q) fill_q[cnt_q] <= biu_q_i;
    end
  end

endmodule

`default_nettype wire

/* dcache/dcache_data_store.sv */
/*
  data store, one line RAM per way
  fill writes whole lines, stores write one word
*/
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_data_store import dcache_addr_pkg::*; (
  input  wire logic    clk_i,
  input  wire adr_t    adr_i,
  input  wire be_t     be_i,
  input  wire word_t   d_i,
  input  wire line_t   fill_line_i,
  output word_t        q_o,
  dcache_array_if.data arr
);

  typedef logic [`DC_BEATS*BE_W-1:0] line_be_t;  // byte enables over a line

  line_t    line_q [`DC_WAYS];
  line_t    wr_line;
  line_be_t wr_be;
  line_t    hit_line;
  line_t    sel_line;

  // fill wins over a store in the same cycle
  always_comb
  begin
    if (arr.fill_we)
    begin
      wr_line = fill_line_i;
      wr_be   = '1;
    end
    else
    begin
      wr_line = {`DC_BEATS{d_i}};                              // word copied to every slot
      wr_be   = line_be_t'(be_i) << (adr_woff(adr_i) * BE_W);  // only one slot enabled
    end
  end

  for (genvar w = 0; w < `DC_WAYS; w++)
  begin : g_way
    ram_1rw #(.WORDS(`DC_SETS), .WIDTH($bits(line_t))) u_line_ram (
      .clk_i (clk_i),
      .adr_i (arr.acc_idx),
      .we_i  (arr.sel_way[w] & (arr.fill_we | arr.store_we)),
      .be_i  (wr_be),
      .d_i   (wr_line),
      .q_o   (line_q[w])
    );
  end

  // ------------------------------
  // way muxes, and-or
  // ------------------------------
  always_comb
  begin
    hit_line = '0;
    sel_line = '0;
    for (int w = 0; w < `DC_WAYS; w++)
    begin
      if (arr.hit[w])     hit_line |= line_q[w];
      if (arr.sel_way[w]) sel_line |= line_q[w];
    end
  end

  assign q_o          = hit_line[adr_woff(adr_i)];  // load word
  assign arr.sel_line = sel_line;                   // victim or flush line

endmodule

`default_nettype wire

/* dcache/dcache_miss_ctrl.sv */
/*
  access FSM for hits, fills on miss and dirty victim write-back
  and the flush walk over all sets
*/
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_miss_ctrl
  import dcache_addr_pkg::*;
  import dcache_ctrl_pkg::*;
(
  input  wire logic    clk_i,
  input  wire logic    rst_ni,
  input  wire logic    req_i,
  input  wire logic    we_i,
  input  wire logic    flush_i,
  input  wire adr_t    adr_i,
  output logic         ack_o,
  output logic         flushrdy_o,
  dcache_array_if.ctrl arr,
  dcache_line_if.miss  line
);

  miss_state_e state_q;
  logic        req_q;         // store outputs belong to adr_i
  logic        flush_pend_q;
  logic        scan_rd_q;     // flush set read is valid
  logic        vdirty_q;      // victim needs write-back
  logic [15:0] lfsr_q;
  idx_t        flush_idx_q;
  way_t        way_q;
  adr_t        evict_adr_q;
  line_t       evict_line_q;
  way_t        victim;
  way_t        flush_way;
  logic        lookup, miss, flushing, flush_start, capture;

  assign lookup      = (state_q == ARMED) & req_q & req_i;
  assign miss        = lookup & ~|arr.hit;
  assign flushing    = (state_q == FLUSH_SCAN) | (state_q == FLUSH_WB);
  assign flush_start = (state_q == ARMED) & flush_pend_q & ~req_i;  // requests first
  assign capture     = miss | ((state_q == FLUSH_SCAN) & scan_rd_q & |arr.dirty_vec);

  assign ack_o      = lookup & |arr.hit;
  assign flushrdy_o = ~flush_pend_q & ~flushing;

  // ------------------------------
  // victim and flush way
  // ------------------------------
  assign victim = way_t'(1) << (lfsr_q % `DC_WAYS);

  always_comb
  begin
    flush_way = '0;
    for (int w = `DC_WAYS-1; w >= 0; w--)
      if (arr.dirty_vec[w]) flush_way = way_t'(1) << w;  // lowest dirty way
  end

  // ------------------------------
  // store and bus controls
  // ------------------------------
  assign arr.acc_idx  = flushing ? flush_idx_q : adr_idx(adr_i);
  assign arr.fill_we  = (state_q == FILL) & line.done;
  assign arr.store_we = we_i & (ack_o | arr.fill_we);  // with a fill the tag goes in dirty
  assign arr.clean_we = (state_q == FLUSH_WB) & line.done;

  always_comb
  begin
    case (state_q)
      ARMED      : arr.sel_way = |arr.hit ? arr.hit : victim;
      FLUSH_SCAN : arr.sel_way = flush_way;
      default    : arr.sel_way = way_q;
    endcase
  end

  always_comb
  begin
    case (state_q)
      FILL            : line.cmd = READ_LINE;
      EVICT, FLUSH_WB : line.cmd = WRITE_LINE;
      default         : line.cmd = NOP;
    endcase
  end

  assign line.line_adr = (state_q == FILL) ? make_adr(adr_tag(adr_i), adr_idx(adr_i))
                                           : evict_adr_q;
  assign line.wline    = evict_line_q;

  // victim line saved before the fill overwrites it
  always_ff @(posedge clk_i)
    if (capture)
    begin
      way_q        <= arr.sel_way;
      evict_adr_q  <= make_adr(arr.victim_tag, arr.acc_idx);
      evict_line_q <= arr.sel_line;
    end

  // ------------------------------
  // FSM
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q      <= ARMED;
      req_q        <= 1'b0;
      flush_pend_q <= 1'b0;
      scan_rd_q    <= 1'b0;
      vdirty_q     <= 1'b0;
      flush_idx_q  <= '0;
      lfsr_q       <= `DC_LFSR_SEED;
    end
    else
    begin
      req_q        <= req_i & ~ack_o;  // retire on ack
      flush_pend_q <= ~flush_start & (flush_pend_q | (flush_i & ~flushing));
      lfsr_q       <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
      case (state_q)
        ARMED      : if (miss)
                     begin
                       state_q  <= FILL;
                       vdirty_q <= |(arr.dirty_vec & victim);
                     end
                     else if (flush_start)
                     begin
                       state_q     <= FLUSH_SCAN;
                       flush_idx_q <= '0;
                       scan_rd_q   <= 1'b0;
                     end
        FILL       : if (line.done) state_q <= vdirty_q ? EVICT : RECOVER;
        EVICT      : if (line.done) state_q <= RECOVER;
        FLUSH_SCAN : if (!scan_rd_q) scan_rd_q <= 1'b1;  // tags of set arrive
                     else if (|arr.dirty_vec)
                     begin
                       state_q   <= FLUSH_WB;
                       scan_rd_q <= 1'b0;
                     end
                     else if (flush_idx_q == idx_t'(`DC_SETS-1)) state_q <= RECOVER;
                     else
                     begin
                       flush_idx_q <= flush_idx_q + 1'b1;
                       scan_rd_q   <= 1'b0;
                     end
        FLUSH_WB   : if (line.done) state_q <= FLUSH_SCAN;  // rescan same set
        default    : state_q <= ARMED;  // RECOVER re-reads the set for the retry
      endcase
    end
  end

endmodule

`default_nettype wire

/* dcache/dcache_tag_store.sv */
/*
  tag store, tags in RAM and valid/dirty in flops
  per-way compare gives the one-hot hit
*/
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_tag_store import dcache_addr_pkg::*; (
  input  wire logic    clk_i,
  input  wire logic    rst_ni,
  input  wire adr_t    adr_i,
  dcache_array_if.tags arr
);

  tag_t tag_q [`DC_WAYS];                     // RAM outputs
  logic [`DC_WAYS-1:0][`DC_SETS-1:0] valid_q;
  logic [`DC_WAYS-1:0][`DC_SETS-1:0] dirty_q;
  idx_t idx_q;                                // set behind the RAM outputs

  always_ff @(posedge clk_i)
    idx_q <= arr.acc_idx;

  for (genvar w = 0; w < `DC_WAYS; w++)
  begin : g_way
    ram_1rw #(.WORDS(`DC_SETS), .WIDTH(TAG_W)) u_tag_ram (
      .clk_i (clk_i),
      .adr_i (arr.acc_idx),
      .we_i  (arr.fill_we & arr.sel_way[w]),
      .be_i  ('1),
      .d_i   (adr_tag(adr_i)),
      .q_o   (tag_q[w])
    );

    assign arr.hit[w]       = valid_q[w][idx_q] & (tag_q[w] == adr_tag(adr_i));
    assign arr.dirty_vec[w] = dirty_q[w][idx_q];
  end

  // tag of the selected way, for victim and flush addresses
  always_comb
  begin
    arr.victim_tag = '0;
    for (int w = 0; w < `DC_WAYS; w++)
      if (arr.sel_way[w]) arr.victim_tag |= tag_q[w];
  end

  // ------------------------------
  // line state
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      valid_q <= '0;  // cold cache
      dirty_q <= '0;
    end
    else
    begin
      for (int w = 0; w < `DC_WAYS; w++)
        if (arr.sel_way[w])
        begin
          if (arr.fill_we)
          begin
            valid_q[w][arr.acc_idx] <= 1'b1;
            dirty_q[w][arr.acc_idx] <= arr.store_we;  // pending store
          end
          else if (arr.store_we) dirty_q[w][arr.acc_idx] <= 1'b1;
          else if (arr.clean_we) dirty_q[w][arr.acc_idx] <= 1'b0;  // written back
        end
    end
  end

endmodule

`default_nettype wire

/* dcache/dcache_top.sv */
/*
  write-back data cache top
  lookup stage, miss stage and burst port wiring
*/
`timescale 1ns/1ps
`default_nettype none

module dcache_top import dcache_addr_pkg::*; (
  input  wire logic  clk_i,
  input  wire logic  rst_ni,

  // CPU side
  input  wire logic  req_i,
  input  wire logic  we_i,
  input  wire adr_t  adr_i,
  input  wire be_t   be_i,
  input  wire word_t d_i,
  output word_t      q_o,
  output logic       ack_o,
  input  wire logic  flush_i,
  output logic       flushrdy_o,

  // memory side
  output logic       biu_stb_o,
  input  wire logic  biu_stb_ack_i,
  output logic       biu_we_o,
  output adr_t       biu_adr_o,
  output word_t      biu_d_o,
  input  wire word_t biu_q_i,
  input  wire logic  biu_ack_i
);

  dcache_array_if arr_if ();
  dcache_line_if  line_if ();

  dcache_miss_ctrl u_miss_ctrl (
    .clk_i, .rst_ni, .req_i, .we_i, .flush_i, .adr_i,
    .ack_o, .flushrdy_o,
    .arr  (arr_if.ctrl),
    .line (line_if.miss)
  );

  dcache_tag_store u_tag_store (
    .clk_i, .rst_ni, .adr_i,
    .arr (arr_if.tags)
  );

  dcache_data_store u_data_store (
    .clk_i, .adr_i, .be_i, .d_i,
    .fill_line_i (line_if.rline),  // written on done
    .q_o,
    .arr         (arr_if.data)
  );

  dcache_bus_ctrl u_bus_ctrl (
    .clk_i, .rst_ni,
    .biu_stb_o, .biu_stb_ack_i, .biu_we_o, .biu_adr_o,
    .biu_d_o, .biu_q_i, .biu_ack_i,
    .line (line_if.bus)
  );

endmodule

`default_nettype wire

/* logic/ram_1rw.sv */
/*
  single port RAM
  registered read, byte masked write
*/
`timescale 1ns/1ps
`default_nettype none

module ram_1rw #(
  parameter int WORDS = 16,
  parameter int WIDTH = 32,
  localparam int AW = (WORDS > 1) ? $clog2(WORDS) : 1,
  localparam int BW = (WIDTH + 7) / 8
) (
  input  wire logic             clk_i,
  input  wire logic [AW-1:0]    adr_i,
  input  wire logic             we_i,
  input  wire logic [BW-1:0]    be_i,
  input  wire logic [WIDTH-1:0] d_i,
  output logic      [WIDTH-1:0] q_o
);

  logic [WIDTH-1:0] mem_q [WORDS];

  always_ff @(posedge clk_i)
  begin
    if (we_i)
      for (int i = 0; i < WIDTH; i++)
        if (be_i[i/8]) mem_q[adr_i][i] <= d_i[i];  // last byte may be partial
    q_o <= mem_q[adr_i];  // old data on a write
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+common
common/dcache_addr_pkg.sv
common/dcache_ctrl_pkg.sv
common/dcache_array_if.sv
common/dcache_line_if.sv
logic/ram_1rw.sv
dcache/dcache_tag_store.sv
dcache/dcache_data_store.sv
dcache/dcache_miss_ctrl.sv
dcache/dcache_bus_ctrl.sv
dcache/dcache_top.sv
sim/tb_memory.sv
sim/dcache_tb.sv

/* sim/dcache_tb.sv */
/*
  data cache testbench
  CPU stimulus, byte shadow reference, load and memory compares
*/
`timescale 1ns/1ps
`default_nettype none

module dcache_tb import dcache_addr_pkg::*; ();

  localparam int          TIMEOUT   = 200;   // cycles per wait
  localparam int          MEM_WORDS = 1024;  // 4 KB behind the cache
  localparam int unsigned SEED      = 32'hbb4d_837e;

  logic  clk_i;
  logic  rst_ni;
  logic  req_i;
  logic  we_i;
  adr_t  adr_i;
  be_t   be_i;
  word_t d_i;
  word_t q_o;
  logic  ack_o;
  logic  flush_i;
  logic  flushrdy_o;
  logic  biu_stb_o;
  logic  biu_stb_ack_i;
  logic  biu_we_o;
  adr_t  biu_adr_o;
  word_t biu_d_o;
  word_t biu_q_i;
  logic  biu_ack_i;

  logic [7:0] shadow_q [MEM_WORDS*BE_W];  // expected byte image
  adr_t       written_q [$];              // store addresses, for the flush check
  int         n_checks;
  int         n_errors;
  int         mark_checks;
  int         mark_errors;
  logic       timed_out;

  dcache_top dut (.*);

  tb_memory #(.WORDS(MEM_WORDS)) u_mem (
    .clk_i, .rst_ni,
    .stb_i     (biu_stb_o),
    .stb_ack_o (biu_stb_ack_i),
    .we_i      (biu_we_o),
    .adr_i     (biu_adr_o),
    .d_i       (biu_d_o),
    .q_o       (biu_q_i),
    .ack_o     (biu_ack_i)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;  // 8 ns
  end

  // ------------------------------
  // reference model
  // ------------------------------
  function automatic word_t pattern_word(int unsigned wi);
    return word_t'(wi) * 32'h9e37_79b9 + 32'h1234_5678;  // memory start value
  endfunction

  // store merges enabled bytes and both kinds return the word
  function automatic word_t ref_access(adr_t a, logic we, be_t be, word_t d);
    word_t       w;
    int unsigned base;
    base = (int'(a) / BE_W % MEM_WORDS) * BE_W;
    for (int b = 0; b < BE_W; b++)
    begin
      if (we && be[b]) shadow_q[base+b] = d[8*b +: 8];
      w[8*b +: 8] = shadow_q[base+b];
    end
    return w;
  endfunction

  task automatic init_shadow();
    word_t w;
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      w = pattern_word(i);
      for (int b = 0; b < BE_W; b++)
        shadow_q[i*BE_W+b] = w[8*b +: 8];
    end
  endtask

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_load(input adr_t a, input word_t got, input word_t exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("ERROR %0t ns: load at %h returned %h, expected %h", $time, a, got, exp);
    end
  endtask

  task automatic check_mem(input adr_t a, input word_t got, input word_t exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("ERROR %0t ns: memory at %h holds %h, expected %h", $time, a, got, exp);
    end
  endtask

  // ack seen mid-cycle and taken at the next rising edge
  always @(negedge clk_i)
  begin : compare_ack
    word_t exp;
    if (rst_ni && req_i && ack_o)
    begin
      exp = ref_access(adr_i, we_i, be_i, d_i);
      if (!we_i) check_load(adr_i, q_o, exp);
    end
  end

  // ------------------------------
  // CPU side drivers
  // ------------------------------
  task automatic cpu_access(input logic we, input adr_t a, input be_t be, input word_t d);
    int n;
    if (!timed_out)
    begin
      @(negedge clk_i);
      req_i = 1'b1;
      we_i  = we;
      adr_i = a;
      be_i  = be;
      d_i   = d;
      if (we) written_q.push_back(a);
      n = 0;
      @(negedge clk_i);
      while (!ack_o && (n < TIMEOUT))
      begin
        @(negedge clk_i);
        n++;
      end
      if (!ack_o)
      begin
        $display("timed out after %0d cycles waiting for ack at address %h", TIMEOUT, a);
        timed_out = 1'b1;
      end
      @(posedge clk_i);  // ack edge
    end
  endtask

  task automatic cpu_idle();
    @(negedge clk_i);
    req_i = 1'b0;
    we_i  = 1'b0;
  endtask

  task automatic flush_all();
    int n;
    if (!timed_out)
    begin
      @(negedge clk_i);
      req_i   = 1'b0;
      flush_i = 1'b1;
      @(negedge clk_i);
      flush_i = 1'b0;  // flushrdy_o low from here
      n = 0;
      while (!flushrdy_o && (n < TIMEOUT))
      begin
        @(negedge clk_i);
        n++;
      end
      if (!flushrdy_o)
      begin
        $display("timed out after %0d cycles waiting for the flush to end", TIMEOUT);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic print_test(input int num, input string name);
    $display("test %0d %s: %0d checks, %0d errors", num, name,
             n_checks - mark_checks, n_errors - mark_errors);
    mark_checks = n_checks;
    mark_errors = n_errors;
  endtask

  // ------------------------------
  // tests
  // ------------------------------
  task automatic run_cold_loads();
    for (int p = 0; p < 2; p++)    // second pass refills replaced lines
      for (int i = 0; i < 48; i++)
        cpu_access(1'b0, adr_t'(i * 20), '0, '0);
    cpu_idle();
  endtask

  task automatic run_byte_stores();
    for (int i = 0; i < 12; i++)  // four lines at 0x100
      cpu_access(1'b1, adr_t'(32'h100 + ($urandom % 16) * 4), be_t'($urandom), word_t'($urandom));
    for (int i = 0; i < 16; i++)
      cpu_access(1'b0, adr_t'(32'h100 + i * 4), '0, '0);
    cpu_idle();
  endtask

  // four tags into one two-way set
  task automatic run_evictions();
    int sets [2];
    sets[0] = 5;
    sets[1] = 9;
    foreach (sets[s])
    begin
      for (int t = 0; t < 4; t++)
        cpu_access(1'b1, adr_t'(t * 256 + sets[s] * 16 + t * 4), '1, word_t'($urandom));
      for (int t = 0; t < 4; t++)
      begin
        cpu_access(1'b0, adr_t'(t * 256 + sets[s] * 16 + t * 4), '0, '0);
        cpu_access(1'b0, adr_t'(t * 256 + sets[s] * 16 + ((t + 1) % 4) * 4), '0, '0);
      end
    end
    cpu_idle();
  endtask

  task automatic check_flushed();
    adr_t a;
    flush_all();
    foreach (written_q[i])
    begin
      a = written_q[i];
      check_mem(a, u_mem.mem_q[int'(a) / BE_W % MEM_WORDS], ref_access(a, 1'b0, '0, '0));
    end
  endtask

  task automatic run_random_traffic();
    for (int i = 0; i < 200; i++)
    begin
      cpu_access(logic'($urandom % 2), adr_t'(($urandom % 512) * 4),
                 be_t'($urandom), word_t'($urandom));
      if (($urandom % 8) == 0) cpu_idle();  // gap now and then
    end
    cpu_idle();
  endtask

  initial
  begin
    void'($urandom(SEED));
    rst_ni      = 1'b0;
    req_i       = 1'b0;
    we_i        = 1'b0;
    adr_i       = '0;
    be_i        = '0;
    d_i         = '0;
    flush_i     = 1'b0;
    n_checks    = 0;
    n_errors    = 0;
    mark_checks = 0;
    mark_errors = 0;
    timed_out   = 1'b0;
    init_shadow();
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    run_cold_loads();
    print_test(1, "cold fills");
    run_byte_stores();
    print_test(2, "byte enabled stores");
    run_evictions();
    print_test(3, "dirty evictions");
    check_flushed();
    print_test(4, "flush write-back");
    run_random_traffic();
    print_test(5, "random traffic");

    $display("total: %0d checks, %0d errors, %0s", n_checks, n_errors,
             timed_out ? "a wait timed out" : "no timeouts");
    if ((n_errors == 0) && !timed_out && (n_checks > 0))
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/tb_memory.sv */
/*
  behavioral burst memory for the cache testbench
  random stalls before the grant and before each beat
*/
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module tb_memory import dcache_addr_pkg::*; #(
  parameter int WORDS = 1024
) (
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  input  wire logic  stb_i,
  output logic       stb_ack_o,
  input  wire logic  we_i,
  input  wire adr_t  adr_i,
  input  wire word_t d_i,
  output word_t      q_o,
  output logic       ack_o
);

  localparam int AW = $clog2(WORDS);
  localparam int LW = AW - WOFF_W;  // line number bits

  word_t         mem_q [WORDS];
  logic          busy_q;   // burst running
  logic          we_q;
  logic [LW-1:0] line_q;
  woff_t         beat_q;
  woff_t         beat_n;

  // known start pattern, every index bit mixed in
  initial
    for (int i = 0; i < WORDS; i++)
      mem_q[i] = word_t'(i) * 32'h9e37_79b9 + 32'h1234_5678;

  // three in four cycles go ahead
  function automatic logic no_stall();
    return ($urandom % 4) != 0;
  endfunction

  assign beat_n = ack_o ? beat_q + 1'b1 : beat_q;  // acked beat was taken at the edge

  // write beats land at the edge that takes them
  always @(posedge clk_i)
    if (ack_o && we_q) mem_q[{line_q, beat_q}] <= d_i;

  // ------------------------------
  // handshake, driven on the falling edge
  // ------------------------------
  always @(negedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      stb_ack_o <= 1'b0;
      ack_o     <= 1'b0;
      busy_q    <= 1'b0;
      we_q      <= 1'b0;
      beat_q    <= '0;
      q_o       <= '0;
    end
    else
    begin
      stb_ack_o <= 1'b0;  // grant lasts one cycle
      ack_o     <= 1'b0;
      if (busy_q)
      begin
        beat_q <= beat_n;
        if (ack_o && (beat_q == woff_t'(`DC_BEATS-1)))
          busy_q <= 1'b0;  // last beat gone
        else if (no_stall())
        begin
          ack_o <= 1'b1;
          q_o   <= mem_q[{line_q, beat_n}];
        end
      end
      else if (stb_ack_o)
      begin
        busy_q <= 1'b1;  // grant taken at the last edge
        beat_q <= '0;
        if (no_stall())
        begin
          ack_o <= 1'b1;
          q_o   <= mem_q[{line_q, woff_t'(0)}];
        end
      end
      else if (stb_i && no_stall())
      begin
        stb_ack_o <= 1'b1;
        we_q      <= we_i;
        line_q    <= adr_i[AW+1:2+WOFF_W];  // line aligned request
      end
    end
  end

endmodule

`default_nettype wire
